// File: src/mc_io_pkg.sv
package mc_io_pkg;

   // mesh coordinate and payload widths
   localparam int unsigned X_W    = 2;
   localparam int unsigned Y_W    = 2;
   localparam int unsigned ADDR_W = 12;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned ID_W   = 5;

   // a store here at the i/o node ends the program, zero data means pass
   localparam logic [ADDR_W-1:0] FINISH_ADDR = 12'hEAD;

   typedef enum logic [1:0]
   {
      OP_STORE = 2'd0,
      OP_LOAD  = 2'd1,
      OP_RESP  = 2'd2
   } mc_op_e;

   // one mesh packet
   // responses carry the request load id back to the requester
   typedef struct packed
   {
      mc_op_e            op;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [ID_W-1:0]   load_id;
      logic [X_W-1:0]    dst_x;
      logic [Y_W-1:0]    dst_y;
      logic [X_W-1:0]    src_x;
      logic [Y_W-1:0]    src_y;
   } mc_packet_s;

   // sticky end-of-run flags
   typedef struct packed
   {
      logic finish;
      logic success;
      logic timeout;
   } mc_status_s;

endpackage

// File: src/spmd_loader.sv
`timescale 1ns/1ps

module spmd_loader
   #(
      parameter int unsigned IMAGE_WORDS = 16,
      parameter int unsigned IO_X        = 3,
      parameter int unsigned IO_Y        = 0
   )
   (
      input  logic                           clk_i,
      input  logic                           arst_n_i,
      input  logic                           prog_v_i,
      input  logic [$clog2(IMAGE_WORDS)-1:0] prog_idx_i,
      input  mc_io_pkg::mc_packet_s          prog_pkt_i,
      input  logic                           start_i,
      input  logic                           take_i,
      output logic                           v_o,
      output mc_io_pkg::mc_packet_s          pkt_o
   );
   import mc_io_pkg::*;

   localparam int unsigned      IDX_W    = $clog2(IMAGE_WORDS);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(IMAGE_WORDS - 1);

   typedef enum logic [1:0] {LD_IDLE, LD_SEND, LD_DONE} ld_state_e;

   ld_state_e        state_q;
   logic [IDX_W-1:0] idx_q;
   mc_packet_s       image_q [IMAGE_WORDS];

   // program image, filled through the load port before start
   always_ff @(posedge clk_i)
   begin
      if (prog_v_i)
      begin
         image_q[prog_idx_i] <= prog_pkt_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= LD_IDLE;
         idx_q   <= '0;
      end
      else
      begin
         case (state_q)
            LD_IDLE:
            begin
               if (start_i)
               begin
                  state_q <= LD_SEND;
                  idx_q   <= '0;
               end
            end
            LD_SEND:
            begin
               // advance only once the monitor has taken the current entry
               if (take_i)
               begin
                  if (idx_q == LAST_IDX)
                  begin
                     state_q <= LD_DONE;
                  end
                  else
                  begin
                     idx_q <= idx_q + 1'b1;
                  end
               end
            end
            LD_DONE:
            begin
               state_q <= LD_DONE;
            end
            default:
            begin
               state_q <= LD_IDLE;
            end
         endcase
      end
   end

   assign v_o = (state_q == LD_SEND);

   // every image entry goes out as a store from the i/o node
   always_comb
   begin
      pkt_o       = image_q[idx_q];
      pkt_o.op    = OP_STORE;
      pkt_o.src_x = X_W'(IO_X);
      pkt_o.src_y = Y_W'(IO_Y);
   end

endmodule

// File: src/ram_model.sv
`timescale 1ns/1ps

module ram_model
   #(
      parameter int unsigned RAM_WORDS  = 256,
      parameter int unsigned RESP_DEPTH = 4,
      parameter int unsigned RAM_X      = 3,
      parameter int unsigned RAM_Y      = 3
   )
   (
      input  logic                  clk_i,
      input  logic                  arst_n_i,
      input  logic                  link_v_i,
      input  mc_io_pkg::mc_packet_s link_pkt_i,
      input  logic                  take_i,
      output logic                  v_o,
      output mc_io_pkg::mc_packet_s pkt_o
   );
   import mc_io_pkg::*;

   localparam int unsigned RAM_AW = $clog2(RAM_WORDS);
   localparam int unsigned PTR_W  = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
   localparam int unsigned CNT_W  = $clog2(RESP_DEPTH + 1);

   logic [DATA_W-1:0]    mem_q [RAM_WORDS];
   logic [RAM_WORDS-1:0] written_q;
   logic [RAM_AW-1:0]    word_idx;
   logic                 hit;
   logic                 do_store;
   logic                 do_load;
   logic                 push;
   logic                 pop;
   mc_packet_s           resp_pkt;
   mc_packet_s           queue_q [RESP_DEPTH];
   logic [PTR_W-1:0]     wr_ptr_q;
   logic [PTR_W-1:0]     rd_ptr_q;
   logic [CNT_W-1:0]     count_q;

   assign word_idx = link_pkt_i.addr[RAM_AW-1:0];
   assign hit      = link_v_i && (link_pkt_i.dst_x == X_W'(RAM_X))
                     && (link_pkt_i.dst_y == Y_W'(RAM_Y));
   assign do_store = hit && (link_pkt_i.op == OP_STORE);
   assign do_load  = hit && (link_pkt_i.op == OP_LOAD);

   // a full queue still accepts a load when an entry drains this cycle
   assign pop  = take_i && (count_q != '0);
   assign push = do_load && ((count_q != CNT_W'(RESP_DEPTH)) || pop);

   always_ff @(posedge clk_i)
   begin
      if (do_store)
      begin
         mem_q[word_idx] <= link_pkt_i.data;
      end
      if (push)
      begin
         queue_q[wr_ptr_q] <= resp_pkt;
      end
   end

   // words never written since reset read back as zero
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         written_q <= '0;
      end
      else if (do_store)
      begin
         written_q[word_idx] <= 1'b1;
      end
   end

   always_comb
   begin
      resp_pkt         = link_pkt_i;
      resp_pkt.op      = OP_RESP;
      resp_pkt.data    = written_q[word_idx] ? mem_q[word_idx] : '0;
      resp_pkt.dst_x   = link_pkt_i.src_x;
      resp_pkt.dst_y   = link_pkt_i.src_y;
      resp_pkt.src_x   = X_W'(RAM_X);
      resp_pkt.src_y   = Y_W'(RAM_Y);
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(RESP_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop)
         begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(RESP_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
      end
   end

   assign v_o   = (count_q != '0);
   assign pkt_o = queue_q[rd_ptr_q];

endmodule

// File: src/io_monitor.sv
`timescale 1ns/1ps

module io_monitor
   #(
      parameter int unsigned CREDITS    = 4,
      parameter int unsigned MAX_CYCLES = 2000,
      parameter int unsigned IO_X       = 3,
      parameter int unsigned IO_Y       = 0
   )
   (
      input  logic                  clk_i,
      input  logic                  arst_n_i,
      input  logic                  link_v_i,
      input  mc_io_pkg::mc_packet_s link_pkt_i,
      input  logic                  link_credit_i,
      input  logic                  ldr_v_i,
      input  mc_io_pkg::mc_packet_s ldr_pkt_i,
      input  logic                  resp_v_i,
      input  mc_io_pkg::mc_packet_s resp_pkt_i,
      output logic                  ldr_take_o,
      output logic                  resp_take_o,
      output logic                  link_v_o,
      output mc_io_pkg::mc_packet_s link_pkt_o,
      output mc_io_pkg::mc_status_s status_o
   );
   import mc_io_pkg::*;

   localparam int unsigned CNT_W = $clog2(CREDITS + 1);
   localparam int unsigned CYC_W = $clog2(MAX_CYCLES + 1);

   logic [CNT_W-1:0] credit_cnt_q;
   logic             can_send;
   logic             send;
   logic             finish_hit;
   logic             finish_q;
   logic             success_q;
   logic [CYC_W-1:0] cycle_cnt_q;

   // memory responses win over loader stores
   assign can_send    = (credit_cnt_q != '0);
   assign resp_take_o = can_send && resp_v_i;
   assign ldr_take_o  = can_send && ldr_v_i && !resp_v_i;
   assign send        = resp_take_o || ldr_take_o;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         credit_cnt_q <= CNT_W'(CREDITS);
      end
      else
      begin
         // a send and a return together cancel out
         case ({send, link_credit_i})
            2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
            2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
            default: credit_cnt_q <= credit_cnt_q;
         endcase
      end
   end

   // outbound register
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         link_v_o <= 1'b0;
      end
      else
      begin
         link_v_o <= send;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (send)
      begin
         link_pkt_o <= resp_take_o ? resp_pkt_i : ldr_pkt_i;
      end
   end

   assign finish_hit = link_v_i && (link_pkt_i.op == OP_STORE)
                       && (link_pkt_i.dst_x == X_W'(IO_X))
                       && (link_pkt_i.dst_y == Y_W'(IO_Y))
                       && (link_pkt_i.addr == FINISH_ADDR);

   // success is latched with the first finish and kept after that
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         finish_q  <= 1'b0;
         success_q <= 1'b0;
      end
      else if (finish_hit && !finish_q)
      begin
         finish_q  <= 1'b1;
         success_q <= (link_pkt_i.data == '0);
      end
   end

   // saturating cycle counter, the timeout stays up once it is reached
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cycle_cnt_q <= '0;
      end
      else if (cycle_cnt_q != CYC_W'(MAX_CYCLES))
      begin
         cycle_cnt_q <= cycle_cnt_q + 1'b1;
      end
   end

   always_comb
   begin
      status_o.finish  = finish_q;
      status_o.success = success_q;
      status_o.timeout = (cycle_cnt_q == CYC_W'(MAX_CYCLES));
   end

endmodule

// File: src/io_complex.sv
`timescale 1ns/1ps

module io_complex
   #(
      parameter int unsigned IMAGE_WORDS = 16,
      parameter int unsigned CREDITS     = 4,
      parameter int unsigned RESP_DEPTH  = 4,
      parameter int unsigned RAM_WORDS   = 256,
      parameter int unsigned MAX_CYCLES  = 2000,
      parameter int unsigned IO_X        = 3,
      parameter int unsigned IO_Y        = 0,
      parameter int unsigned RAM_X       = 3,
      parameter int unsigned RAM_Y       = 3
   )
   (
      input  logic                           clk_i,
      input  logic                           arst_n_i,
      input  logic                           link_v_i,
      input  mc_io_pkg::mc_packet_s          link_pkt_i,
      input  logic                           link_credit_i,
      output logic                           link_v_o,
      output mc_io_pkg::mc_packet_s          link_pkt_o,
      input  logic                           prog_v_i,
      input  logic [$clog2(IMAGE_WORDS)-1:0] prog_idx_i,
      input  mc_io_pkg::mc_packet_s          prog_pkt_i,
      input  logic                           start_i,
      output mc_io_pkg::mc_status_s          status_o
   );
   import mc_io_pkg::*;

   logic       ldr_v;
   logic       ldr_take;
   mc_packet_s ldr_pkt;
   logic       resp_v;
   logic       resp_take;
   mc_packet_s resp_pkt;

   spmd_loader
      #(
         .IMAGE_WORDS (IMAGE_WORDS),
         .IO_X        (IO_X),
         .IO_Y        (IO_Y)
      )
   spmd_loader_inst
      (
         .clk_i      (clk_i),
         .arst_n_i   (arst_n_i),
         .prog_v_i   (prog_v_i),
         .prog_idx_i (prog_idx_i),
         .prog_pkt_i (prog_pkt_i),
         .start_i    (start_i),
         .take_i     (ldr_take),
         .v_o        (ldr_v),
         .pkt_o      (ldr_pkt)
      );

   ram_model
      #(
         .RAM_WORDS  (RAM_WORDS),
         .RESP_DEPTH (RESP_DEPTH),
         .RAM_X      (RAM_X),
         .RAM_Y      (RAM_Y)
      )
   ram_model_inst
      (
         .clk_i      (clk_i),
         .arst_n_i   (arst_n_i),
         .link_v_i   (link_v_i),
         .link_pkt_i (link_pkt_i),
         .take_i     (resp_take),
         .v_o        (resp_v),
         .pkt_o      (resp_pkt)
      );

   io_monitor
      #(
         .CREDITS    (CREDITS),
         .MAX_CYCLES (MAX_CYCLES),
         .IO_X       (IO_X),
         .IO_Y       (IO_Y)
      )
   io_monitor_inst
      (
         .clk_i         (clk_i),
         .arst_n_i      (arst_n_i),
         .link_v_i      (link_v_i),
         .link_pkt_i    (link_pkt_i),
         .link_credit_i (link_credit_i),
         .ldr_v_i       (ldr_v),
         .ldr_pkt_i     (ldr_pkt),
         .resp_v_i      (resp_v),
         .resp_pkt_i    (resp_pkt),
         .ldr_take_o    (ldr_take),
         .resp_take_o   (resp_take),
         .link_v_o      (link_v_o),
         .link_pkt_o    (link_pkt_o),
         .status_o      (status_o)
      );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
   #(
      parameter int unsigned HALF_NS      = 2,
      parameter int unsigned RESET_CYCLES = 16
   )
   (
      output logic clk_o,
      output logic arst_n_o
   );

   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #(HALF_NS) clk_o = ~clk_o;
      end
   end

   // reset released just after a rising edge
   initial
   begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1;
      arst_n_o = 1'b1;
   end

endmodule

// File: dv/io_complex_asserts.sv
`timescale 1ns/1ps

module io_complex_asserts
   #(
      parameter int unsigned CREDITS = 4
   )
   (
      input logic                             clk_i,
      input logic                             arst_n_i,
      input logic [$clog2(CREDITS + 1)-1:0]   credit_cnt_i,
      input logic                             ldr_take_i,
      input logic                             resp_take_i,
      input logic                             out_v_i
   );

   localparam int unsigned CNT_W = $clog2(CREDITS + 1);

   credit_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      credit_cnt_i <= CNT_W'(CREDITS))
      else $error("credit count went above the number of link credits");

   // a packet on the link needs a credit in the cycle it was taken
   send_needs_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_v_i |-> ($past(credit_cnt_i) != '0))
      else $error("outbound packet sent while no credit was left");

   one_take: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(ldr_take_i && resp_take_i))
      else $error("loader and memory response taken in the same cycle");

endmodule

bind io_monitor io_complex_asserts
   #(
      .CREDITS (CREDITS)
   )
   io_complex_asserts_inst
   (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .credit_cnt_i (credit_cnt_q),
      .ldr_take_i   (ldr_take_o),
      .resp_take_i  (resp_take_o),
      .out_v_i      (link_v_o)
   );

// File: dv/io_complex_tb.sv
`timescale 1ns/1ps

module io_complex_tb;
   import mc_io_pkg::*;

   localparam int unsigned IMAGE_WORDS  = 16;
   localparam int unsigned CREDITS      = 4;
   localparam int unsigned MAX_CYCLES   = 2000;
   localparam int unsigned IO_X         = 3;
   localparam int unsigned IO_Y         = 0;
   localparam int unsigned IDX_W        = $clog2(IMAGE_WORDS);
   localparam int unsigned VEC_W        = 84;
   localparam int unsigned MAX_VECS     = 64;
   localparam int unsigned EXP_DEPTH    = 64;
   localparam int unsigned QUIET_CYCLES = 20;

   logic             clk;
   logic             arst_n;
   logic             link_v_i;
   mc_packet_s       link_pkt_i;
   logic             link_credit_i = 1'b0;
   logic             link_v_o;
   mc_packet_s       link_pkt_o;
   logic             prog_v_i;
   logic [IDX_W-1:0] prog_idx_i;
   mc_packet_s       prog_pkt_i;
   logic             start_i;
   mc_status_s       status_o;

   logic [VEC_W-1:0] vec_mem [MAX_VECS];
   int unsigned      n_vec;
   int unsigned      vec_idx;
   int unsigned      cycle_limit;
   int unsigned      cycle_cnt;
   mc_packet_s       image_mirror [IMAGE_WORDS];
   // expected outbound streams filled by the stimulus and drained by the link checker
   mc_packet_s       exp_resp_mem [EXP_DEPTH];
   mc_packet_s       exp_store_mem [EXP_DEPTH];
   int unsigned      resp_wr;
   int unsigned      resp_rd;
   int unsigned      store_wr;
   int unsigned      store_rd;
   int unsigned      rx_cnt;
   int unsigned      held_cnt;
   int unsigned      credit_cnt;
   int unsigned      delay_cnt;
   logic             credit_hold;
   logic             credit_due;
   integer           seed = 32'hf292;

   tb_clock_gen
      #(
         .HALF_NS      (2),
         .RESET_CYCLES (16)
      )
   tb_clock_gen_inst
      (
         .clk_o    (clk),
         .arst_n_o (arst_n)
      );

   io_complex
      #(
         .IMAGE_WORDS (IMAGE_WORDS),
         .CREDITS     (CREDITS),
         .MAX_CYCLES  (MAX_CYCLES),
         .IO_X        (IO_X),
         .IO_Y        (IO_Y)
      )
   io_complex_inst
      (
         .clk_i         (clk),
         .arst_n_i      (arst_n),
         .link_v_i      (link_v_i),
         .link_pkt_i    (link_pkt_i),
         .link_credit_i (link_credit_i),
         .link_v_o      (link_v_o),
         .link_pkt_o    (link_pkt_o),
         .prog_v_i      (prog_v_i),
         .prog_idx_i    (prog_idx_i),
         .prog_pkt_i    (prog_pkt_i),
         .start_i       (start_i),
         .status_o      (status_o)
      );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_packet(input string what, input mc_packet_s got, input mc_packet_s exp);
      if (got !== exp)
      begin
         report_failure($sformatf("error at %0d ns: %s packet mismatch, got %h expected %h",
                                  $time, what, got, exp));
      end
   endtask

   task automatic check_status(input mc_status_s got, input mc_status_s exp);
      if (got !== exp)
      begin
         report_failure($sformatf("error at %0d ns: status mismatch, got %b expected %b",
                                  $time, got, exp));
      end
   endtask

   // vector fields from the top are kind, idx, op, addr, data, load id and dst x/y, src x/y
   function automatic mc_packet_s vec_to_packet(input logic [VEC_W-1:0] v);
      mc_packet_s p;
      p.op      = mc_op_e'(v[69:68]);
      p.addr    = v[67:56];
      p.data    = v[55:24];
      p.load_id = v[20:16];
      p.dst_x   = v[13:12];
      p.dst_y   = v[9:8];
      p.src_x   = v[5:4];
      p.src_y   = v[1:0];
      return p;
   endfunction

   // an image entry leaves as a store sourced from the i/o node
   function automatic mc_packet_s loader_store(input mc_packet_s img);
      mc_packet_s p;
      p       = img;
      p.op    = OP_STORE;
      p.src_x = X_W'(IO_X);
      p.src_y = Y_W'(IO_Y);
      return p;
   endfunction

   task automatic run_vector(input logic [VEC_W-1:0] v);
      logic [3:0]  kind;
      mc_packet_s  pkt;
      mc_status_s  exp_status;
      int unsigned count_arg;
      int unsigned k;
      kind       = v[83:80];
      pkt        = vec_to_packet(v);
      exp_status = mc_status_s'(v[74:72]);
      count_arg  = 32'(v[79:72]);
      @(posedge clk);
      #1;
      link_v_i = 1'b0;
      prog_v_i = 1'b0;
      start_i  = 1'b0;
      case (kind)
         4'h1:
         begin
            prog_v_i   = 1'b1;
            prog_idx_i = v[72 +: IDX_W];
            prog_pkt_i = pkt;
            image_mirror[v[72 +: IDX_W]] = pkt;
         end
         4'h2:
         begin
            start_i = 1'b1;
            for (k = 0; k < IMAGE_WORDS; k++)
            begin
               exp_store_mem[store_wr % EXP_DEPTH] = loader_store(image_mirror[k]);
               store_wr = store_wr + 1;
            end
         end
         4'h3:
         begin
            link_v_i   = 1'b1;
            link_pkt_i = pkt;
         end
         4'h4:
         begin
            exp_resp_mem[resp_wr % EXP_DEPTH] = pkt;
            resp_wr = resp_wr + 1;
         end
         4'h6:
         begin
            while ((resp_rd != resp_wr) || (store_rd != store_wr))
            begin
               @(posedge clk);
            end
         end
         4'h7:
         begin
            credit_hold = 1'b1;
         end
         4'h8:
         begin
            // wait for the credited packets and then watch for any extra one
            while (held_cnt < count_arg)
            begin
               @(posedge clk);
            end
            repeat (QUIET_CYCLES) @(posedge clk);
            if (held_cnt != count_arg)
            begin
               report_failure($sformatf("error at %0d ns: %0d packets sent without credits, %s %0d",
                                        $time, held_cnt, "expected", count_arg));
            end
            #1;
            credit_hold = 1'b0;
         end
         4'h9:
         begin
            @(negedge clk);
            check_status(status_o, exp_status);
         end
         4'ha:
         begin
            while (!status_o.timeout)
            begin
               @(negedge clk);
            end
            check_status(status_o, exp_status);
         end
         default:
         begin
            report_failure($sformatf("vector file holds an unknown line kind %h", kind));
         end
      endcase
   endtask

   // outbound packets are sorted by opcode into their own expected streams
   always @(negedge clk)
   begin
      if (arst_n && link_v_o)
      begin
         if (link_pkt_o.op == OP_RESP)
         begin
            if (resp_rd == resp_wr)
            begin
               report_failure("a memory response left the I/O node when none was expected");
            end
            else
            begin
               check_packet("response", link_pkt_o, exp_resp_mem[resp_rd % EXP_DEPTH]);
               resp_rd = resp_rd + 1;
            end
         end
         else if (link_pkt_o.op == OP_STORE)
         begin
            if (store_rd == store_wr)
            begin
               report_failure("a loader store left the I/O node when none was expected");
            end
            else
            begin
               check_packet("loader store", link_pkt_o, exp_store_mem[store_rd % EXP_DEPTH]);
               store_rd = store_rd + 1;
            end
         end
         else
         begin
            report_failure("a packet with a load opcode appeared on the outbound link");
         end
         rx_cnt = rx_cnt + 1;
         if (credit_hold)
         begin
            held_cnt = held_cnt + 1;
         end
      end
   end

   // one credit back per received packet after a short random delay
   always @(posedge clk)
   begin
      credit_due = !credit_hold && (rx_cnt != credit_cnt);
      #1;
      link_credit_i = 1'b0;
      if (credit_due)
      begin
         if (delay_cnt == 0)
         begin
            link_credit_i = 1'b1;
            credit_cnt    = credit_cnt + 1;
            delay_cnt     = $unsigned($random(seed)) % 4;
         end
         else
         begin
            delay_cnt = delay_cnt - 1;
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
      begin
         report_failure($sformatf("test hung, still running after %0d clock cycles", cycle_cnt));
      end
   end

   initial
   begin
      link_v_i    = 1'b0;
      link_pkt_i  = '0;
      prog_v_i    = 1'b0;
      prog_idx_i  = '0;
      prog_pkt_i  = '0;
      start_i     = 1'b0;
      credit_hold = 1'b0;
      for (vec_idx = 0; vec_idx < MAX_VECS; vec_idx++)
      begin
         vec_mem[vec_idx] = '0;
      end
      $readmemh("dv/io_complex_vectors.txt", vec_mem);
      n_vec = 0;
      while ((n_vec < MAX_VECS) && (vec_mem[n_vec][83:80] != 4'h0))
      begin
         n_vec = n_vec + 1;
      end
      cycle_limit = n_vec * 20 + MAX_CYCLES;
      if (n_vec == 0)
      begin
         report_failure("no stimulus lines could be read from dv/io_complex_vectors.txt");
      end
      wait (arst_n === 1'b1);
      for (vec_idx = 0; vec_idx < n_vec; vec_idx++)
      begin
         run_vector(vec_mem[vec_idx]);
      end
      if ((resp_rd == resp_wr) && (store_rd == store_wr))
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
      else
      begin
         report_failure("some expected outbound packets never arrived");
      end
   end

endmodule

// File: io_complex.f
src/mc_io_pkg.sv
src/spmd_loader.sv
src/ram_model.sv
src/io_monitor.sv
src/io_complex.sv
dv/tb_clock_gen.sv
dv/io_complex_asserts.sv
dv/io_complex_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = io_complex_tb
FILELIST = io_complex.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/io_complex_vectors.txt
// kind_idx_op_addr_data_id_xyxy, last group is dst x, dst y, src x, src y
// kind 1 image, 2 start, 3 inbound, 4 expected response, 6 drain, 7 hold, 8 release, 9/a status
1_00_0_100_a5a50000_00_0100
1_01_0_101_a5a50011_00_1100
1_02_0_102_a5a50022_00_2100
1_03_0_103_a5a50033_00_0200
1_04_0_104_a5a50044_00_1200
1_05_0_105_a5a50055_00_2200
1_06_0_106_a5a50066_00_0100
1_07_0_107_a5a50077_00_1100
1_08_0_200_5a5a0088_00_2100
1_09_0_201_5a5a0099_00_0200
1_0a_0_202_5a5a00aa_00_1200
1_0b_0_203_5a5a00bb_00_2200
1_0c_0_204_5a5a00cc_00_0100
1_0d_0_205_5a5a00dd_00_1100
1_0e_0_206_5a5a00ee_00_2100
1_0f_0_207_5a5a00ff_00_0200
7_00_0_000_00000000_00_0000
2_00_0_000_00000000_00_0000
8_04_0_000_00000000_00_0000
4_00_2_010_cafef00d_0a_1233
4_00_2_020_00000000_0b_2133
3_00_0_010_cafef00d_00_3312
3_00_1_010_00000000_0a_3312
3_00_1_020_00000000_0b_3321
6_00_0_000_00000000_00_0000
9_00_0_000_00000000_00_0000
3_00_0_ead_00000000_00_2012
3_00_1_030_00000000_0c_1112
6_00_0_000_00000000_00_0000
9_00_0_000_00000000_00_0000
3_00_0_ead_00000000_00_3012
9_06_0_000_00000000_00_0000
a_07_0_000_00000000_00_0000
